//--- Bender.yml
package:
  name: ln_stats_front

sources:
  - files:
      - rtl/ln_pkg.sv
      - rtl/ln_row_fifo.sv
      - rtl/ln_stats.sv
      - rtl/ln_center.sv
      - rtl/ln_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_ln_top.sv

//--- project.f
+incdir+include
rtl/ln_pkg.sv
rtl/ln_row_fifo.sv
rtl/ln_stats.sv
rtl/ln_center.sv
rtl/ln_top.sv
tb/tb_ln_top.sv

//--- rtl/ln_center.sv
module ln_center import ln_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  lane_t                 mean,
    input  var_t                  var_out,
    input  logic                  stats_vld,
    input  logic [BEAT_CNT_W-1:0] row_beats,
    input  bus_t                  fifo_dout,
    input  logic                  fifo_empty,
    output logic                  fifo_rd,
    output bus_t                  out_data,
    output logic                  out_vld,
    output logic                  out_last,
    output var_t                  out_var
);

    // beats still to be read for the current row
    logic [BEAT_CNT_W-1:0] rd_cnt;
    lane_t                 mean_c;
    logic                  rd_last;

    // first step of the delay line, fifo data valid
    logic rd_vld_d1;
    logic last_d1;

    assign fifo_rd = (rd_cnt != '0) && !fifo_empty;
    assign rd_last = fifo_rd && (rd_cnt == BEAT_CNT_W'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_cnt <= '0;
        end else if (stats_vld) begin
            rd_cnt <= row_beats;
        end else if (fifo_rd) begin
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    // held for the whole drain
    always_ff @(posedge clk) begin
        if (stats_vld) begin
            mean_c  <= mean;
            out_var <= var_out;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_vld_d1 <= 1'b0;
            last_d1   <= 1'b0;
            out_vld   <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            rd_vld_d1 <= fifo_rd;
            last_d1   <= rd_last;
            out_vld   <= rd_vld_d1;
            out_last  <= last_d1;
        end
    end

    // wraps modulo 2^8 per lane
    always_ff @(posedge clk) begin
        if (rd_vld_d1) begin
            for (int i = 0; i < BUS_NUM; i++) begin
                out_data[i] <= fifo_dout[i] - mean_c;
            end
        end
    end

endmodule

//--- rtl/ln_pkg.sv
package ln_pkg;

    // lanes per beat and element width
    localparam int BUS_NUM = 4;
    localparam int LANE_W  = 8;

    // a squared element and the variance share one width
    localparam int SQR_W   = 16;

    // accumulators for the plain sum and the sum of squares
    localparam int SUM_W   = 24;
    localparam int SQSUM_W = 32;

    // row length and scale shift inputs
    localparam int NUM_W   = 10;
    localparam int SHIFT_W = 5;

    // longest row in beats, also the row buffer depth
    localparam int MAX_BEATS  = 16;
    // must hold MAX_BEATS itself, not only MAX_BEATS-1
    localparam int BEAT_CNT_W = $clog2(MAX_BEATS + 1);

    typedef logic signed [LANE_W-1:0] lane_t;

    // lane 0 sits in the low byte
    typedef lane_t [BUS_NUM-1:0] bus_t;

    typedef logic [SQR_W-1:0] var_t;

endpackage

//--- rtl/ln_row_fifo.sv
module ln_row_fifo import ln_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic wr,
    input  bus_t din,
    input  logic rd,
    output bus_t dout,
    output logic empty
);

    localparam int PTR_W = $clog2(MAX_BEATS);

    bus_t mem [MAX_BEATS];

    logic [PTR_W-1:0]      wptr;
    logic [PTR_W-1:0]      rptr;
    logic [BEAT_CNT_W-1:0] count;
    logic                  do_wr;
    logic                  do_rd;
    logic                  full;

    assign full  = (count == BEAT_CNT_W'(MAX_BEATS));
    assign empty = (count == '0);

    // writes into a full buffer are dropped, reads from an empty one hold dout
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rptr];
        end
    end

endmodule

//--- rtl/ln_stats.sv
module ln_stats import ln_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [NUM_W-1:0]      in_data_num,
    input  logic                  in_data_num_vld,
    input  logic [SHIFT_W-1:0]    in_scale_pos,
    input  logic                  in_scale_pos_vld,
    input  bus_t                  in_data,
    input  logic                  in_data_vld,
    output logic                  fifo_wr,
    output bus_t                  fifo_din,
    output lane_t                 mean,
    output var_t                  var_out,
    output logic                  stats_vld,
    output logic [BEAT_CNT_W-1:0] row_beats
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DIV,
        ST_VAR
    } state_t;

    state_t state;

    // registered input beat
    bus_t beat_q;
    logic beat_vld_q;

    logic [NUM_W-1:0]      num_q;
    logic [BEAT_CNT_W-1:0] beats_q;
    logic [SHIFT_W-1:0]    shift_q;
    logic [BEAT_CNT_W-1:0] beat_cnt;

    logic signed [SUM_W-1:0] sum_acc;
    logic [SQSUM_W-1:0]      sqsum_acc;

    // per-beat lane sums
    logic signed [SQR_W-1:0] lane_sq [BUS_NUM];
    logic signed [SUM_W-1:0] beat_sum;
    logic [SQSUM_W-1:0]      beat_sqsum;

    logic signed [SUM_W-1:0] num_s;
    lane_t                   mean_q;
    var_t                    msq_q;
    logic signed [SQR_W-1:0] mean_sq;
    var_t                    var_q;
    logic                    stats_vld_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_vld_q <= 1'b0;
        end else begin
            beat_vld_q <= in_data_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (in_data_vld) begin
            beat_q <= in_data;
        end
    end

    always_comb begin
        beat_sum   = '0;
        beat_sqsum = '0;
        for (int i = 0; i < BUS_NUM; i++) begin
            lane_sq[i] = beat_q[i] * beat_q[i];
            beat_sum   += SUM_W'(beat_q[i]);
            beat_sqsum += SQSUM_W'(lane_sq[i]);
        end
    end

    // signed divisor so the mean truncates toward zero
    assign num_s   = SUM_W'(num_q);
    assign mean_sq = mean_q * mean_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= ST_IDLE;
            num_q       <= '0;
            beats_q     <= '0;
            beat_cnt    <= '0;
            sum_acc     <= '0;
            sqsum_acc   <= '0;
            stats_vld_q <= 1'b0;
        end else begin
            stats_vld_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (in_data_num_vld) begin
                        num_q   <= in_data_num;
                        beats_q <= BEAT_CNT_W'(in_data_num / BUS_NUM);
                        state   <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (beat_vld_q) begin
                        sum_acc   <= sum_acc + beat_sum;
                        sqsum_acc <= sqsum_acc + beat_sqsum;
                        if (beat_cnt + 1'b1 == beats_q) begin
                            beat_cnt <= '0;
                            state    <= ST_DIV;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_DIV: begin
                    state <= ST_VAR;
                end
                default: begin
                    // variance lands this cycle, sums restart for the next row
                    sum_acc     <= '0;
                    sqsum_acc   <= '0;
                    stats_vld_q <= 1'b1;
                    state       <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DIV) begin
            mean_q <= lane_t'(sum_acc / num_s);
            msq_q  <= var_t'(sqsum_acc / SQSUM_W'(num_q));
        end
        if (state == ST_VAR) begin
            var_q <= (msq_q >> shift_q) - var_t'(mean_sq);
        end
    end

    // shift persists across rows until reloaded
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_q <= '0;
        end else if (in_scale_pos_vld) begin
            shift_q <= in_scale_pos;
        end
    end

    assign fifo_wr   = (state == ST_LOAD) && beat_vld_q;
    assign fifo_din  = beat_q;
    assign mean      = mean_q;
    assign var_out   = var_q;
    assign stats_vld = stats_vld_q;
    assign row_beats = beats_q;

endmodule

//--- rtl/ln_top.sv
module ln_top import ln_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic [NUM_W-1:0]   in_data_num,
    input  logic               in_data_num_vld,
    input  logic [SHIFT_W-1:0] in_scale_pos,
    input  logic               in_scale_pos_vld,
    input  bus_t               in_data,
    input  logic               in_data_vld,
    output bus_t               out_data,
    output logic               out_vld,
    output logic               out_last,
    output var_t               out_var
);

    logic                  fifo_wr;
    bus_t                  fifo_din;
    logic                  fifo_rd;
    bus_t                  fifo_dout;
    logic                  fifo_empty;
    lane_t                 mean;
    var_t                  var_out;
    logic                  stats_vld;
    logic [BEAT_CNT_W-1:0] row_beats;

    ln_stats i_stats (
        .clk              (clk),
        .rstn             (rstn),
        .in_data_num      (in_data_num),
        .in_data_num_vld  (in_data_num_vld),
        .in_scale_pos     (in_scale_pos),
        .in_scale_pos_vld (in_scale_pos_vld),
        .in_data          (in_data),
        .in_data_vld      (in_data_vld),
        .fifo_wr          (fifo_wr),
        .fifo_din         (fifo_din),
        .mean             (mean),
        .var_out          (var_out),
        .stats_vld        (stats_vld),
        .row_beats        (row_beats)
    );

    // one row of raw beats waits here until the mean is known
    ln_row_fifo i_row_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (fifo_wr),
        .din   (fifo_din),
        .rd    (fifo_rd),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    ln_center i_center (
        .clk        (clk),
        .rstn       (rstn),
        .mean       (mean),
        .var_out    (var_out),
        .stats_vld  (stats_vld),
        .row_beats  (row_beats),
        .fifo_dout  (fifo_dout),
        .fifo_empty (fifo_empty),
        .fifo_rd    (fifo_rd),
        .out_data   (out_data),
        .out_vld    (out_vld),
        .out_last   (out_last),
        .out_var    (out_var)
    );

endmodule

//--- include/ln_vectors.svh
`ifndef LN_VECTORS_SVH
`define LN_VECTORS_SVH

// columns: len, load_shift, shift, fixed, neg, fill, gaps
// len counts elements, fill only matters for fixed rows, shift only when load_shift is set
typedef struct packed {
    logic [NUM_W-1:0]   len;
    logic               load_shift;
    logic [SHIFT_W-1:0] shift;
    logic               fixed;
    logic               neg;
    logic [7:0]         fill;
    logic               gaps;
} vec_t;

localparam int NUM_VEC = 9;

vec_t vec_table [NUM_VEC];

task automatic fill_vectors();
    vec_table[0] = {10'd16, 1'b1, 5'd0, 1'b1, 1'b0, 8'd25,  1'b0};
    vec_table[1] = {10'd32, 1'b0, 5'd0, 1'b0, 1'b0, 8'd0,   1'b0};
    vec_table[2] = {10'd4,  1'b1, 5'd2, 1'b0, 1'b0, 8'd0,   1'b0};
    vec_table[3] = {10'd64, 1'b0, 5'd0, 1'b0, 1'b0, 8'd0,   1'b1};
    vec_table[4] = {10'd24, 1'b1, 5'd0, 1'b0, 1'b1, 8'd0,   1'b1};
    vec_table[5] = {10'd12, 1'b1, 5'd3, 1'b1, 1'b0, 8'hf9,  1'b0};
    vec_table[6] = {10'd40, 1'b0, 5'd0, 1'b0, 1'b1, 8'd0,   1'b0};
    vec_table[7] = {10'd20, 1'b1, 5'd1, 1'b0, 1'b0, 8'd0,   1'b1};
    vec_table[8] = {10'd64, 1'b0, 5'd0, 1'b0, 1'b1, 8'd0,   1'b0};
endtask

`endif

//--- tb/tb_ln_top.sv
module tb_ln_top import ln_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int QUIET_CYCLES = 8;

    logic               clk = 1'b0;
    logic               rstn;
    logic [NUM_W-1:0]   in_data_num;
    logic               in_data_num_vld;
    logic [SHIFT_W-1:0] in_scale_pos;
    logic               in_scale_pos_vld;
    bus_t               in_data;
    logic               in_data_vld;
    bus_t               out_data;
    logic               out_vld;
    logic               out_last;
    var_t               out_var;

    integer seed = 32'h8dc0;
    int     mismatches = 0;
    int     failures = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    int     cur_shift;

    // beats of the row currently in flight, kept for the model
    bus_t sent [MAX_BEATS];

    `include "ln_vectors.svh"

    always #10 clk = ~clk;

    ln_top i_dut (
        .clk              (clk),
        .rstn             (rstn),
        .in_data_num      (in_data_num),
        .in_data_num_vld  (in_data_num_vld),
        .in_scale_pos     (in_scale_pos),
        .in_scale_pos_vld (in_scale_pos_vld),
        .in_data          (in_data),
        .in_data_vld      (in_data_vld),
        .out_data         (out_data),
        .out_vld          (out_vld),
        .out_last         (out_last),
        .out_var          (out_var)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            failures++;
            $display("ERROR: run stopped after %0d cycles, a row never finished", cycles);
            $display("checks %0d, mismatches %0d, other errors %0d",
                     checks, mismatches, failures);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare(input string what, input logic signed [31:0] actual,
                           input logic signed [31:0] expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, actual, expected);
        end
    endtask

    // nothing may come out while a row is still being sent
    task automatic expect_quiet(input string phase);
        if (out_vld !== 1'b0 || out_last !== 1'b0) begin
            failures++;
            $display("ERROR: output beat appeared at %0t during %s", $time, phase);
        end
    endtask

    task automatic send_row(input int r);
        int    beats;
        int    rnd;
        lane_t lane;
        beats           = vec_table[r].len / BUS_NUM;
        in_data_num     = vec_table[r].len;
        in_data_num_vld = 1'b1;
        if (vec_table[r].load_shift) begin
            in_scale_pos     = vec_table[r].shift;
            in_scale_pos_vld = 1'b1;
        end
        @(negedge clk);
        expect_quiet($sformatf("input of row %0d", r));
        in_data_num_vld  = 1'b0;
        in_scale_pos_vld = 1'b0;
        for (int b = 0; b < beats; b++) begin
            // idle cycle before every odd beat
            if (vec_table[r].gaps && (b % 2 == 1)) begin
                in_data_vld = 1'b0;
                @(negedge clk);
                expect_quiet($sformatf("input of row %0d", r));
            end
            for (int i = 0; i < BUS_NUM; i++) begin
                rnd = $random(seed);
                if (vec_table[r].fixed) begin
                    lane = vec_table[r].fill;
                end else if (vec_table[r].neg) begin
                    lane = {1'b1, rnd[6:0]};
                end else begin
                    lane = rnd[7:0];
                end
                sent[b][i] = lane;
            end
            in_data     = sent[b];
            in_data_vld = 1'b1;
            @(negedge clk);
            expect_quiet($sformatf("input of row %0d", r));
        end
        in_data_vld = 1'b0;
    endtask

    // signed sum over the row, truncated toward zero
    function automatic lane_t model_mean(input int beats);
        int sum;
        sum = 0;
        for (int b = 0; b < beats; b++) begin
            for (int i = 0; i < BUS_NUM; i++) begin
                sum += int'(sent[b][i]);
            end
        end
        return lane_t'(sum / (beats * BUS_NUM));
    endfunction

    function automatic var_t model_var(input int beats, input int shift, input lane_t m);
        int sqsum;
        int msq;
        sqsum = 0;
        for (int b = 0; b < beats; b++) begin
            for (int i = 0; i < BUS_NUM; i++) begin
                sqsum += int'(sent[b][i]) * int'(sent[b][i]);
            end
        end
        msq = sqsum / (beats * BUS_NUM);
        return var_t'((msq >> shift) - int'(m) * int'(m));
    endfunction

    task automatic collect_row(input int r, input int beats, input lane_t m, input var_t v);
        lane_t exp_lane;
        while (out_vld !== 1'b1) begin
            @(negedge clk);
        end
        for (int b = 0; b < beats; b++) begin
            if (out_vld !== 1'b1) begin
                failures++;
                $display("ERROR: row %0d output stopped after %0d of %0d beats", r, b, beats);
                return;
            end
            for (int i = 0; i < BUS_NUM; i++) begin
                exp_lane = lane_t'(int'(sent[b][i]) - int'(m));
                compare($sformatf("row %0d beat %0d lane %0d", r, b, i),
                        out_data[i], exp_lane);
            end
            compare($sformatf("row %0d beat %0d out_var", r, b), out_var, v);
            if (b == beats - 1 && out_last !== 1'b1) begin
                failures++;
                $display("ERROR: row %0d has no out_last on its final beat", r);
            end else if (b < beats - 1 && out_last !== 1'b0) begin
                failures++;
                $display("ERROR: row %0d raised out_last early on beat %0d", r, b);
            end
            @(negedge clk);
        end
        if (out_vld !== 1'b0) begin
            failures++;
            $display("ERROR: row %0d produced an extra beat after out_last", r);
        end
    endtask

    initial begin
        lane_t exp_mean;
        var_t  exp_var;
        int    beats;
        rstn             = 1'b0;
        in_data_num      = '0;
        in_data_num_vld  = 1'b0;
        in_scale_pos     = '0;
        in_scale_pos_vld = 1'b0;
        in_data          = '0;
        in_data_vld      = 1'b0;
        fill_vectors();
        cycle_limit = 2 + QUIET_CYCLES;
        for (int r = 0; r < NUM_VEC; r++) begin
            cycle_limit += 3 * (vec_table[r].len / BUS_NUM) + 20;
        end
        repeat (2) begin
            @(negedge clk);
            expect_quiet("reset");
        end
        rstn      = 1'b1;
        cur_shift = 0;
        for (int r = 0; r < NUM_VEC; r++) begin
            // shift stays loaded across rows
            if (vec_table[r].load_shift) begin
                cur_shift = vec_table[r].shift;
            end
            beats = vec_table[r].len / BUS_NUM;
            send_row(r);
            exp_mean = model_mean(beats);
            exp_var  = model_var(beats, cur_shift, exp_mean);
            collect_row(r, beats, exp_mean, exp_var);
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            expect_quiet("end of run");
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
